//--- run_sim.sh
#!/bin/sh
# build the testbench with Verilator and run it from the project root
cd "$(dirname "$0")" || exit 1

verilator --binary --assert --timing -Wno-fatal \
    --top-module tb_spi_slave -f sources.f -o tb_spi_slave \
    && ./obj_dir/tb_spi_slave | tee /dev/stderr | grep -q "Result: PASSED" \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }

//--- sources.f
src/spi_cfg_pkg.sv
src/spi_state_pkg.sv
src/spi_pin_sync.sv
src/spi_shift_engine.sv
src/spi_char_buffer.sv
src/spi_slave_top.sv
verif/tb_spi_slave.sv

//--- src/spi_cfg_pkg.sv
package spi_cfg_pkg;

    // widest character the slave handles by default
    parameter int CHAR_NBITS = 16;

    // width of the char_len field, length is char_len+1 bits
    parameter int LEN_W = 4;

    // first transmit pattern after reset
    parameter logic [15:0] TX_SEED = 16'haa50;

    // clock phase as seen from the slave
    typedef enum logic
    {
        SAMPLE_FIRST = 1'b0,  // cpha low, sample on leading edge
        LAUNCH_FIRST = 1'b1   // cpha high, launch on leading edge
    } spi_phase_e;

endpackage

//--- src/spi_char_buffer.sv
`timescale 1ns/1ps

module spi_char_buffer
#(
    parameter int CHAR_NBITS = spi_cfg_pkg::CHAR_NBITS
)
(
    input  logic                  S_CHAR_GO,
    input  logic                  S_RESETN,
    input  logic                  tx_only,
    input  logic                  char_end,
    input  logic [CHAR_NBITS-1:0] rx_shift,
    output logic [CHAR_NBITS-1:0] tx_char,
    output logic [CHAR_NBITS-1:0] rx_char,
    output logic                  char_done
);

    import spi_cfg_pkg::*;

    always_ff @(posedge S_CHAR_GO or negedge S_RESETN)
    begin
        if (!S_RESETN)
        begin
            tx_char   <= CHAR_NBITS'(TX_SEED);
            rx_char   <= '0;
            char_done <= 1'b0;
        end
        else
        begin
            char_done <= char_end;
            if (char_end)
            begin
                tx_char <= tx_char + 1'b1;  // next pattern, same cycle as done
                if (!tx_only)
                    rx_char <= rx_shift;    // unread value is overwritten
            end
        end
    end

    // one pulse per character
    assert property (@(posedge S_CHAR_GO) disable iff (!S_RESETN)
        char_done |=> !char_done);

endmodule

//--- src/spi_pin_sync.sv
`timescale 1ns/1ps

module spi_pin_sync
(
    input  logic S_CHAR_GO,
    input  logic S_RESETN,
    input  logic enable,
    input  logic cpol,
    input  logic spi_sck,
    input  logic spi_mosi,
    output logic sck_lead,
    output logic sck_trail,
    output logic mosi_bit,
    output logic frame_on
);

    logic [2:0] sync_q1;   // {enable, mosi, sck}, first stage
    logic [2:0] sync_q2;   // second stage
    logic       sck_prev;  // sck one cycle older
    logic       sck_rise;
    logic       sck_fall;

    assign sck_rise = sync_q2[0] & ~sck_prev;
    assign sck_fall = ~sync_q2[0] & sck_prev;

    always_ff @(posedge S_CHAR_GO or negedge S_RESETN)
    begin
        if (!S_RESETN)
        begin
            sync_q1   <= '0;
            sync_q2   <= '0;
            sck_prev  <= 1'b0;
            sck_lead  <= 1'b0;
            sck_trail <= 1'b0;
            mosi_bit  <= 1'b0;
            frame_on  <= 1'b0;
        end
        else
        begin
            sync_q1  <= {enable, spi_mosi, spi_sck};
            sync_q2  <= sync_q1;
            sck_prev <= sync_q2[0];
            // cpol high means the idle level is high, so the fall leads
            sck_lead  <= cpol ? sck_fall : sck_rise;
            sck_trail <= cpol ? sck_rise : sck_fall;
            mosi_bit  <= sync_q2[1];  // kept aligned with the edge pulses
            frame_on  <= sync_q2[2];
        end
    end

endmodule

//--- src/spi_shift_engine.sv
`timescale 1ns/1ps

module spi_shift_engine
#(
    parameter int CHAR_NBITS = spi_cfg_pkg::CHAR_NBITS
)
(
    input  logic                          S_CHAR_GO,
    input  logic                          S_RESETN,
    input  logic                          cpha,
    input  logic                          rev,
    input  logic [spi_cfg_pkg::LEN_W-1:0] char_len,
    input  logic                          sck_lead,
    input  logic                          sck_trail,
    input  logic                          mosi_bit,
    input  logic                          frame_on,
    input  logic [CHAR_NBITS-1:0]         tx_char,
    output logic                          spi_miso,
    output logic                          char_end,
    output logic [CHAR_NBITS-1:0]         rx_shift
);

    import spi_cfg_pkg::*;
    import spi_state_pkg::*;

    localparam int IDX_W = $clog2(CHAR_NBITS);

    shift_state_e     state;
    spi_phase_e       phase;
    logic [LEN_W-1:0] bit_cnt;      // samples left to take minus one
    logic [LEN_W-1:0] tx_pos;       // number of the next bit to launch
    logic             frame_spent;  // one character per frame
    logic             sample_edge;
    logic             launch_edge;

    // maps bit number n to its vector position in either bit order
    function automatic logic [IDX_W-1:0] bit_sel(input logic [LEN_W-1:0] n);
        logic [LEN_W-1:0] pos;
        pos = rev ? n : char_len - n;
        return IDX_W'(pos);
    endfunction

    assign phase       = spi_phase_e'(cpha);
    assign sample_edge = (phase == SAMPLE_FIRST) ? sck_lead : sck_trail;
    assign launch_edge = (phase == LAUNCH_FIRST) ? sck_lead : sck_trail;
    assign char_end    = (state == FINISH);

    always_ff @(posedge S_CHAR_GO or negedge S_RESETN)
    begin
        if (!S_RESETN)
        begin
            state       <= IDLE;
            bit_cnt     <= '0;
            tx_pos      <= '0;
            spi_miso    <= 1'b1;
            frame_spent <= 1'b0;
        end
        else if (!frame_on)
        begin
            state       <= IDLE;  // aborted without char_end
            spi_miso    <= 1'b1;
            frame_spent <= 1'b0;
        end
        else
        begin
            case (state)
                IDLE:
                begin
                    spi_miso <= 1'b1;
                    if (!frame_spent)
                        state <= ARMED;
                end
                ARMED:
                begin
                    bit_cnt <= char_len;
                    if (phase == SAMPLE_FIRST)
                    begin
                        spi_miso <= tx_char[bit_sel(LEN_W'(0))];  // first bit now
                        tx_pos   <= LEN_W'(1);
                    end
                    else
                        tx_pos <= '0;  // first bit waits for leading edge
                    state <= SHIFT;
                end
                SHIFT:
                begin
                    if (launch_edge)
                    begin
                        spi_miso <= tx_char[bit_sel(tx_pos)];
                        tx_pos   <= tx_pos + 1'b1;
                    end
                    if (sample_edge)
                    begin
                        if (bit_cnt == '0)
                            state <= FINISH;
                        else
                            bit_cnt <= bit_cnt - 1'b1;
                    end
                end
                FINISH:
                begin
                    spi_miso    <= 1'b1;
                    frame_spent <= 1'b1;  // rearm only after enable drops
                    state       <= IDLE;
                end
                default:
                    state <= IDLE;
            endcase
        end
    end

    // receive bits land right-aligned with upper bits zero
    always_ff @(posedge S_CHAR_GO)
    begin
        if (state == ARMED)
            rx_shift <= '0;
        else if (state == SHIFT && frame_on && sample_edge)
            rx_shift[bit_sel(char_len - bit_cnt)] <= mosi_bit;
    end

    // mode and length must hold for the whole character
    assert property (@(posedge S_CHAR_GO) disable iff (!S_RESETN)
        (state != IDLE) |-> $stable({cpha, rev, char_len}));

    // the synchronizer never reports both edges at once
    assert property (@(posedge S_CHAR_GO) disable iff (!S_RESETN)
        !(sck_lead && sck_trail));

endmodule

//--- src/spi_slave_top.sv
`timescale 1ns/1ps

module spi_slave_top
#(
    parameter int CHAR_NBITS = spi_cfg_pkg::CHAR_NBITS
)
(
    input  logic                          S_CHAR_GO,
    input  logic                          S_RESETN,
    input  logic                          enable,
    input  logic                          cpol,
    input  logic                          cpha,
    input  logic                          tx_only,
    input  logic                          rev,
    input  logic [spi_cfg_pkg::LEN_W-1:0] char_len,
    input  logic                          spi_sck,
    input  logic                          spi_mosi,
    output logic                          spi_miso,
    output logic                          char_done,
    output logic [CHAR_NBITS-1:0]         rx_char
);

    logic                  sck_lead;
    logic                  sck_trail;
    logic                  mosi_bit;
    logic                  frame_on;
    logic [CHAR_NBITS-1:0] tx_char;
    logic                  char_end;
    logic [CHAR_NBITS-1:0] rx_shift;

    spi_pin_sync spi_pin_sync_inst
    (
        .S_CHAR_GO (S_CHAR_GO),
        .S_RESETN  (S_RESETN),
        .enable    (enable),
        .cpol      (cpol),
        .spi_sck   (spi_sck),
        .spi_mosi  (spi_mosi),
        .sck_lead  (sck_lead),
        .sck_trail (sck_trail),
        .mosi_bit  (mosi_bit),
        .frame_on  (frame_on)
    );

    spi_shift_engine #(.CHAR_NBITS(CHAR_NBITS)) spi_shift_engine_inst
    (
        .S_CHAR_GO (S_CHAR_GO),
        .S_RESETN  (S_RESETN),
        .cpha      (cpha),
        .rev       (rev),
        .char_len  (char_len),
        .sck_lead  (sck_lead),
        .sck_trail (sck_trail),
        .mosi_bit  (mosi_bit),
        .frame_on  (frame_on),
        .tx_char   (tx_char),
        .spi_miso  (spi_miso),
        .char_end  (char_end),
        .rx_shift  (rx_shift)
    );

    spi_char_buffer #(.CHAR_NBITS(CHAR_NBITS)) spi_char_buffer_inst
    (
        .S_CHAR_GO (S_CHAR_GO),
        .S_RESETN  (S_RESETN),
        .tx_only   (tx_only),
        .char_end  (char_end),
        .rx_shift  (rx_shift),
        .tx_char   (tx_char),
        .rx_char   (rx_char),
        .char_done (char_done)
    );

endmodule

//--- src/spi_state_pkg.sv
package spi_state_pkg;

    // shift engine states
    typedef enum logic [1:0]
    {
        IDLE   = 2'd0,  // waiting for a frame
        ARMED  = 2'd1,  // counter load, first bit
        SHIFT  = 2'd2,  // bits moving on sck edges
        FINISH = 2'd3   // last bit sampled
    } shift_state_e;

endpackage

//--- verif/spi_stim.txt
# name cpol cpha rev tx_only char_len abort mosi miso_expected rx_expected
# words in hex, right-aligned to char_len+1 bits; abort lines ignore the miso column
# the transmit pattern starts at aa50 and steps once per completed character
m0_msb16          0 0 0 0 15 0 1234 aa50 1234
m1_msb16          0 1 0 0 15 0 c3a5 aa51 c3a5
m2_msb16          1 0 0 0 15 0 5a0f aa52 5a0f
m3_msb16          1 1 0 0 15 0 f00d aa53 f00d
m0_rev16          0 0 1 0 15 0 8001 aa54 8001
m1_rev8           0 1 1 0 7  0 12c3 0055 00c3
m2_rev4           1 0 1 0 3  0 000b 0006 000b
m3_rev8           1 1 1 0 7  0 00e7 0057 00e7
m0_msb8           0 0 0 0 7  0 003c 0058 003c
m3_msb4           1 1 0 0 3  0 0009 0009 0009
txonly_m0         0 0 0 1 15 0 ffff aa5a 0009
txonly_m3         1 1 0 1 7  0 0055 005b 0009
abort_m0          0 0 0 0 15 1 7777 0000 0009
after_abort_m0    0 0 0 0 15 0 2468 aa5c 2468
abort_m3_rev8     1 1 1 0 7  1 00aa 0000 2468
after_abort_m3    1 1 1 0 7  0 00aa 005d 00aa
m1_msb16_zero     0 1 0 0 15 0 0000 aa5e 0000
m2_rev16_ones     1 0 1 0 15 0 ffff aa5f ffff
m0_msb2           0 0 0 0 1  0 0002 0000 0002
m2_msb12          1 0 0 0 11 0 0abc 0a61 0abc

//--- verif/tb_spi_slave.sv
`timescale 1ns/1ps

module tb_spi_slave;

    import spi_cfg_pkg::*;

    localparam int NBITS     = 16;
    localparam int HALF_CYC  = 10;   // system cycles per sck half period
    localparam int DONE_WAIT = 400;
    localparam int DONE_LAT  = 5;    // last sampling pin edge to char_done

    logic             S_CHAR_GO;
    logic             S_RESETN;
    logic             enable;
    logic             cpol;
    logic             cpha;
    logic             tx_only;
    logic             rev;
    logic [LEN_W-1:0] char_len;
    logic             spi_sck;
    logic             spi_mosi;
    logic             spi_miso;
    logic             char_done;
    logic [NBITS-1:0] rx_char;

    int               cyc;          // falling edges seen so far
    int               done_cnt;     // char_done pulses seen so far
    int               done_cyc;
    logic [NBITS-1:0] rx_at_done;
    logic [NBITS-1:0] miso_word;    // bits collected by the master
    int               tests_ok;
    int               tests_bad;

    spi_slave_top #(.CHAR_NBITS(NBITS)) spi_slave_top_inst
    (
        .S_CHAR_GO (S_CHAR_GO),
        .S_RESETN  (S_RESETN),
        .enable    (enable),
        .cpol      (cpol),
        .cpha      (cpha),
        .tx_only   (tx_only),
        .rev       (rev),
        .char_len  (char_len),
        .spi_sck   (spi_sck),
        .spi_mosi  (spi_mosi),
        .spi_miso  (spi_miso),
        .char_done (char_done),
        .rx_char   (rx_char)
    );

    always #2 S_CHAR_GO = ~S_CHAR_GO;

    // one system cycle, outputs are read at the falling edge
    task automatic advance();
        @(negedge S_CHAR_GO);
        cyc = cyc + 1;
        if (char_done)
        begin
            done_cnt   = done_cnt + 1;
            done_cyc   = cyc;
            rx_at_done = rx_char;
        end
    endtask

    task automatic wait_cycles(input int n);
        for (int i = 0; i < n; i++)
            advance();
    endtask

    task automatic wait_done(input int start, output logic seen);
        int n;
        n = 0;
        while (done_cnt == start && n < DONE_WAIT)
        begin
            advance();
            n = n + 1;
        end
        seen = (done_cnt != start);
    endtask

    // master side of one character, edge_at marks the last sampling pin edge
    task automatic drive_char(input logic rev_v, input int len, input logic abort_v,
                              input logic [NBITS-1:0] mosi, output int edge_at);
        int   nbits;
        int   pos;
        logic lead_lvl;
        nbits     = abort_v ? (len + 1) / 2 : len + 1;
        lead_lvl  = ~cpol;
        miso_word = '0;
        edge_at   = 0;
        enable    = 1'b1;
        wait_cycles(8);  // frame reaches the engine
        for (int i = 0; i < nbits; i++)
        begin
            pos = rev_v ? i : len - i;
            if (spi_phase_e'(cpha) == SAMPLE_FIRST)
            begin
                spi_mosi = mosi[pos];
                wait_cycles(HALF_CYC);
                miso_word[pos] = spi_miso;
                spi_sck        = lead_lvl;
                edge_at        = cyc;
                wait_cycles(HALF_CYC);
                spi_sck = cpol;
            end
            else
            begin
                spi_sck  = lead_lvl;
                spi_mosi = mosi[pos];
                wait_cycles(HALF_CYC);
                miso_word[pos] = spi_miso;
                spi_sck        = cpol;
                edge_at        = cyc;
                wait_cycles(HALF_CYC);
            end
        end
    endtask

    task automatic run_test(input string name, input int cpol_v, input int cpha_v,
                            input int rev_v, input int txo_v, input int len_v,
                            input int abort_v, input logic [NBITS-1:0] mosi,
                            input logic [NBITS-1:0] miso_exp,
                            input logic [NBITS-1:0] rx_exp);
        int   errs;
        int   start;
        int   edge_at;
        int   gap;
        logic seen;
        errs     = 0;
        cpol     = cpol_v[0];
        cpha     = cpha_v[0];
        rev      = rev_v[0];
        tx_only  = txo_v[0];
        char_len = LEN_W'(len_v);
        spi_sck  = cpol_v[0];  // idle level before the frame opens
        spi_mosi = 1'b0;
        wait_cycles(4);
        start = done_cnt;
        drive_char(rev_v[0], len_v, abort_v[0], mosi, edge_at);
        if (abort_v != 0)
        begin
            enable  = 1'b0;
            spi_sck = cpol_v[0];
            wait_done(start, seen);  // timing out is the good outcome here
            if (seen)
            begin
                $display("error at %0t ns: char_done pulsed for an aborted character", $time);
                errs = errs + 1;
            end
            if (rx_char !== rx_exp)
            begin
                $display("error at %0t ns: rx_char expected %h got %h", $time, rx_exp, rx_char);
                errs = errs + 1;
            end
            if (spi_miso !== 1'b1)
            begin
                $display("error at %0t ns: spi_miso expected 1 got %b", $time, spi_miso);
                errs = errs + 1;
            end
        end
        else
        begin
            wait_done(start, seen);
            if (!seen)
            begin
                $display("timeout at %0t ns: char_done never came within %0d cycles",
                         $time, DONE_WAIT);
                errs = errs + 1;
            end
            else
            begin
                if (done_cyc - edge_at != DONE_LAT)
                begin
                    $display("error at %0t ns: char_done delay expected %0d got %0d",
                             $time, DONE_LAT, done_cyc - edge_at);
                    errs = errs + 1;
                end
                if (rx_at_done !== rx_exp)
                begin
                    $display("error at %0t ns: rx_char expected %h got %h",
                             $time, rx_exp, rx_at_done);
                    errs = errs + 1;
                end
                if (miso_word !== miso_exp)
                begin
                    $display("error at %0t ns: spi_miso expected %h got %h",
                             $time, miso_exp, miso_word);
                    errs = errs + 1;
                end
            end
            enable = 1'b0;
        end
        gap = 2 + int'($urandom % 8);
        wait_cycles(gap);
        if (errs == 0)
        begin
            tests_ok = tests_ok + 1;
            $display("test %s ok", name);
        end
        else
        begin
            tests_bad = tests_bad + 1;
            $display("test %s failed with %0d errors", name, errs);
        end
    endtask

    initial
    begin
        int               fd;
        int               nf;
        int               ntests;
        int               errs;
        string            line;
        string            name;
        int               cpol_v;
        int               cpha_v;
        int               rev_v;
        int               txo_v;
        int               len_v;
        int               abort_v;
        logic [NBITS-1:0] mosi_v;
        logic [NBITS-1:0] miso_exp;
        logic [NBITS-1:0] rx_exp;

        S_CHAR_GO  = 1'b0;
        S_RESETN   = 1'b0;
        enable     = 1'b0;
        cpol       = 1'b0;
        cpha       = 1'b0;
        tx_only    = 1'b0;
        rev        = 1'b0;
        char_len   = '0;
        spi_sck    = 1'b0;
        spi_mosi   = 1'b0;
        cyc        = 0;
        done_cnt   = 0;
        done_cyc   = 0;
        rx_at_done = '0;
        miso_word  = '0;
        tests_ok   = 0;
        tests_bad  = 0;
        ntests     = 0;
        errs       = 0;
        void'($urandom(64));

        wait_cycles(3);
        S_RESETN = 1'b1;
        wait_cycles(2);
        if (spi_miso !== 1'b1)
        begin
            $display("error at %0t ns: spi_miso expected 1 got %b", $time, spi_miso);
            errs = errs + 1;
        end
        if (char_done !== 1'b0 || done_cnt != 0)
        begin
            $display("error at %0t ns: char_done expected 0 got %b", $time, char_done);
            errs = errs + 1;
        end
        if (rx_char !== '0)
        begin
            $display("error at %0t ns: rx_char expected 0000 got %h", $time, rx_char);
            errs = errs + 1;
        end
        if (errs == 0)
        begin
            tests_ok = tests_ok + 1;
            $display("test reset_state ok");
        end
        else
        begin
            tests_bad = tests_bad + 1;
            $display("test reset_state failed with %0d errors", errs);
        end

        fd = $fopen("verif/spi_stim.txt", "r");
        if (fd == 0)
        begin
            $display("could not open verif/spi_stim.txt, no character tests ran");
            tests_bad = tests_bad + 1;
        end
        else
        begin
            while (!$feof(fd))
            begin
                line = "";
                nf   = $fgets(line, fd);
                nf   = $sscanf(line, "%s %d %d %d %d %d %d %h %h %h", name, cpol_v,
                               cpha_v, rev_v, txo_v, len_v, abort_v, mosi_v,
                               miso_exp, rx_exp);
                if (nf == 10)  // comment and blank lines fall through
                begin
                    ntests = ntests + 1;
                    run_test(name, cpol_v, cpha_v, rev_v, txo_v, len_v, abort_v,
                             mosi_v, miso_exp, rx_exp);
                end
            end
            $fclose(fd);
            if (ntests == 0)
            begin
                $display("the stimulus file held no test lines");
                tests_bad = tests_bad + 1;
            end
        end

        $display("tests passed %0d, failed %0d", tests_ok, tests_bad);
        if (tests_bad == 0)
            $display("Result: PASSED");
        else
            $display("Result: FAILED");
        $finish;
    end

endmodule
